// ==== src/icache_pkg.sv ====
// Geometry constants and FSM encodings shared by every block of the private instruction cache
`default_nettype none

package icache_pkg;

   localparam int CACHE_SIZE       = 4096;               // Capacity in bytes
   localparam int FETCH_ADDR_WIDTH = 32;                 // Fetch and refill address
   localparam int FETCH_DATA_WIDTH = 32;                 // One instruction word
   localparam int LINE_WIDTH       = 128;                // Refill line
   localparam int LINE_BYTES       = LINE_WIDTH / 8;

   localparam int NB_WAYS   = 4;
   localparam int WAY_WIDTH = $clog2(NB_WAYS);           // Round-robin pointer
   localparam int NB_SETS   = CACHE_SIZE / (NB_WAYS * LINE_BYTES);

   // Address split
   localparam int SET_WIDTH      = $clog2(NB_SETS);
   localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);
   localparam int WORD_SEL_WIDTH = $clog2(LINE_WIDTH / FETCH_DATA_WIDTH);
   localparam int TAG_WIDTH      = FETCH_ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;
   localparam int SET_LSB        = OFFSET_WIDTH;
   localparam int SET_MSB        = SET_LSB + SET_WIDTH - 1;
   localparam int TAG_LSB        = SET_MSB + 1;

   // Refill buffers
   localparam int REFILL_FIFO_DEPTH = 2;
   localparam int REFILL_PTR_WIDTH  = $clog2(REFILL_FIFO_DEPTH);
   localparam int REFILL_CNT_WIDTH  = $clog2(REFILL_FIFO_DEPTH + 1);

   // Controller states
   localparam int         ST_WIDTH     = 3;
   localparam logic [2:0] ST_FLUSH     = 3'd0;       // Invalidate walk
   localparam logic [2:0] ST_IDLE      = 3'd1;       // Ready for a fetch
   localparam logic [2:0] ST_LOOKUP    = 3'd2;       // Tag compare
   localparam logic [2:0] ST_MISS_REQ  = 3'd3;       // Push line address
   localparam logic [2:0] ST_MISS_WAIT = 3'd4;       // Wait for the line

endpackage

`default_nettype wire

// ==== src/icache_if.sv ====
// Interfaces that carry tag and data memory accesses from the cache controller to the banks
`default_nettype none

interface icache_tag_if;
   logic                                rd_en;     // Lookup strobe
   logic                                wr_en;
   logic [icache_pkg::SET_WIDTH-1:0]    set;
   logic [icache_pkg::TAG_WIDTH-1:0]    tag;       // Compare or write tag
   logic [icache_pkg::NB_WAYS-1:0]      wr_way;    // One-hot
   logic                                wr_valid;  // Low while flushing
   logic [icache_pkg::NB_WAYS-1:0]      hit;       // One cycle after rd_en

   modport ctrl (output rd_en, wr_en, set, tag, wr_way, wr_valid, input hit);
   modport bank (input rd_en, wr_en, set, tag, wr_way, wr_valid, output hit);
endinterface

interface icache_data_if;
   logic                                rd_en;
   logic                                wr_en;
   logic [icache_pkg::SET_WIDTH-1:0]    set;
   logic [icache_pkg::NB_WAYS-1:0]      wr_way;    // One-hot
   logic [icache_pkg::LINE_WIDTH-1:0]   wdata;
   logic [icache_pkg::NB_WAYS-1:0]      rd_way;    // Tag hit forwarded by the controller
   logic [icache_pkg::LINE_WIDTH-1:0]   rdata;

   modport ctrl (output rd_en, wr_en, set, wr_way, wdata, rd_way, input rdata);
   modport bank (input rd_en, wr_en, set, wr_way, wdata, rd_way, output rdata);
endinterface

`default_nettype wire

// ==== src/icache_tag_bank.sv ====
// Tag and valid storage for all ways, compared against the lookup tag one cycle after a read
`default_nettype none

module icache_tag_bank (
   input  wire             clk,
   icache_tag_if.bank      tag_if
);

   logic [icache_pkg::TAG_WIDTH-1:0] tag_mem [icache_pkg::NB_WAYS][icache_pkg::NB_SETS];
   logic                             valid_mem [icache_pkg::NB_WAYS][icache_pkg::NB_SETS];

   logic [icache_pkg::SET_WIDTH-1:0] rd_set_q;  // Set of the pending lookup
   logic [icache_pkg::TAG_WIDTH-1:0] rd_tag_q;  // Tag to compare
   logic                             rd_q;      // Hit vector is meaningful

   always_ff @(posedge clk)
   begin
      rd_q <= tag_if.rd_en;
      if (tag_if.rd_en)
      begin
         rd_set_q <= tag_if.set;
         rd_tag_q <= tag_if.tag;
      end
      // Flush writes all ways at once, refill only one
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (tag_if.wr_en && tag_if.wr_way[w])
         begin
            tag_mem[w][tag_if.set]   <= tag_if.tag;
            valid_mem[w][tag_if.set] <= tag_if.wr_valid;
         end
      end
   end

   // One comparator per way
   always_comb
   begin
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         tag_if.hit[w] = valid_mem[w][rd_set_q] && (tag_mem[w][rd_set_q] == rd_tag_q);
      end
   end

   // A line is never allocated twice, so a lookup matches at most one way
   a_hit_onehot : assert property (@(posedge clk) rd_q |-> $onehot0(tag_if.hit));

endmodule

`default_nettype wire

// ==== src/icache_data_bank.sv ====
// Line storage for all ways; the line of the way that hit is chosen by the forwarded hit vector
`default_nettype none

module icache_data_bank (
   input  wire             clk,
   icache_data_if.bank     data_if
);

   logic [icache_pkg::LINE_WIDTH-1:0] line_mem [icache_pkg::NB_WAYS][icache_pkg::NB_SETS];
   logic [icache_pkg::LINE_WIDTH-1:0] rd_line_q [icache_pkg::NB_WAYS];  // All ways of one set

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (data_if.wr_en && data_if.wr_way[w])
         begin
            line_mem[w][data_if.set] <= data_if.wdata;
         end
         if (data_if.rd_en)
         begin
            rd_line_q[w] <= line_mem[w][data_if.set];  // Read all, select later
         end
      end
   end

   // AND-OR mux, rd_way is one-hot or zero
   always_comb
   begin
      data_if.rdata = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         if (data_if.rd_way[w])
         begin
            data_if.rdata = data_if.rdata | rd_line_q[w];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/icache_refill_buffer.sv ====
// Small FIFO that decouples the cache from the next memory level on refill requests and responses
`default_nettype none

module icache_refill_buffer #(
   parameter int unsigned DATA_WIDTH = 32
) (
   input  wire                     clk,
   input  wire                     rst_i,
   input  wire                     push_valid_i,
   input  wire  [DATA_WIDTH-1:0]   push_data_i,
   output logic                    push_ready_o,
   output logic                    pop_valid_o,
   output logic [DATA_WIDTH-1:0]   pop_data_o,
   input  wire                     pop_ready_i
);

   logic [DATA_WIDTH-1:0]                   mem_q [icache_pkg::REFILL_FIFO_DEPTH];
   logic [icache_pkg::REFILL_PTR_WIDTH-1:0] wr_ptr_q;
   logic [icache_pkg::REFILL_PTR_WIDTH-1:0] rd_ptr_q;
   logic [icache_pkg::REFILL_CNT_WIDTH-1:0] count_q;   // Entries held
   logic                                    push;
   logic                                    pop;

   assign push_ready_o = (count_q != (icache_pkg::REFILL_CNT_WIDTH)'(icache_pkg::REFILL_FIFO_DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign pop_data_o   = mem_q[rd_ptr_q];                // Head entry
   assign push         = push_valid_i && push_ready_o;
   assign pop          = pop_valid_o && pop_ready_i;

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= (wr_ptr_q == (icache_pkg::REFILL_PTR_WIDTH)'(icache_pkg::REFILL_FIFO_DEPTH - 1))
                        ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= (rd_ptr_q == (icache_pkg::REFILL_PTR_WIDTH)'(icache_pkg::REFILL_FIFO_DEPTH - 1))
                        ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + (icache_pkg::REFILL_CNT_WIDTH)'(push)
                            - (icache_pkg::REFILL_CNT_WIDTH)'(pop);
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   // Only one refill is outstanding at a time, so the FIFO never fills up
   a_no_push_full : assert property (@(posedge clk) disable iff (rst_i)
      push_valid_i |-> push_ready_o);

endmodule

`default_nettype wire

// ==== src/icache_controller.sv ====
// Cache controller FSM handling lookup, miss refill, bypass and whole-cache flush
`default_nettype none

module icache_controller (
   input  wire                                         clk,
   input  wire                                         rst_i,
   // Fetch port
   input  wire                                         fetch_req_i,
   input  wire  [icache_pkg::FETCH_ADDR_WIDTH-1:0]     fetch_addr_i,
   output logic                                        fetch_gnt_o,
   output logic                                        fetch_rvalid_o,
   output logic [icache_pkg::FETCH_DATA_WIDTH-1:0]     fetch_rdata_o,
   // Mode control
   input  wire                                         bypass_icache_i,
   output logic                                        cache_is_bypassed_o,
   input  wire                                         flush_icache_i,
   output logic                                        cache_is_flushed_o,
   // Memories
   icache_tag_if.ctrl                                  tag_if,
   icache_data_if.ctrl                                 data_if,
   // Refill request push and response pop
   output logic                                        req_valid_o,
   output logic [icache_pkg::FETCH_ADDR_WIDTH-1:0]     req_addr_o,
   input  wire                                         req_ready_i,
   input  wire                                         resp_valid_i,
   input  wire  [icache_pkg::LINE_WIDTH-1:0]           resp_data_i
);

   logic [icache_pkg::ST_WIDTH-1:0]         state_q, state_d;
   logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] addr_q;         // Fetch in flight
   logic [icache_pkg::SET_WIDTH-1:0]        flush_set_q;
   logic [icache_pkg::WAY_WIDTH-1:0]        rr_q;           // Victim way
   logic [icache_pkg::NB_WAYS-1:0]          alloc_way;
   logic [icache_pkg::WORD_SEL_WIDTH-1:0]   word_sel;
   logic                                    bypass_q;
   logic                                    flushed_q;
   logic                                    lookup_hit;
   logic                                    alloc;
   logic                                    miss_rvalid_q;  // Refill answer, one cycle late
   logic [icache_pkg::FETCH_DATA_WIDTH-1:0] miss_rdata_q;

   assign word_sel  = addr_q[icache_pkg::OFFSET_WIDTH-1 -: icache_pkg::WORD_SEL_WIDTH];
   assign alloc_way = (icache_pkg::NB_WAYS)'(1) << rr_q;
   assign alloc     = (state_q == icache_pkg::ST_MISS_WAIT) && resp_valid_i && !bypass_q;
   assign lookup_hit = (state_q == icache_pkg::ST_LOOKUP) && (|tag_if.hit);

   // Fetch port outputs
   assign fetch_gnt_o    = (state_q == icache_pkg::ST_IDLE) && !flush_icache_i;
   assign fetch_rvalid_o = lookup_hit || miss_rvalid_q;
   assign fetch_rdata_o  = miss_rvalid_q ? miss_rdata_q
      : data_if.rdata[word_sel*icache_pkg::FETCH_DATA_WIDTH +: icache_pkg::FETCH_DATA_WIDTH];

   assign cache_is_bypassed_o = bypass_q;
   assign cache_is_flushed_o  = flushed_q;
   assign req_addr_o = {addr_q[icache_pkg::FETCH_ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH],
                        {icache_pkg::OFFSET_WIDTH{1'b0}}};   // Line aligned

   //////////////////////////////////////////////////////////////////////
   // Next state and memory strobes
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d          = state_q;
      req_valid_o      = 1'b0;
      tag_if.rd_en     = 1'b0;
      tag_if.wr_en     = 1'b0;
      tag_if.set       = addr_q[icache_pkg::SET_MSB:icache_pkg::SET_LSB];
      tag_if.tag       = addr_q[icache_pkg::FETCH_ADDR_WIDTH-1:icache_pkg::TAG_LSB];
      tag_if.wr_way    = alloc_way;
      tag_if.wr_valid  = 1'b1;
      data_if.rd_en    = 1'b0;
      data_if.wr_en    = alloc;
      data_if.set      = addr_q[icache_pkg::SET_MSB:icache_pkg::SET_LSB];
      data_if.wr_way   = alloc_way;
      data_if.wdata    = resp_data_i;
      data_if.rd_way   = tag_if.hit;                      // Saves a second compare

      case (state_q)
         icache_pkg::ST_FLUSH:
         begin
            tag_if.wr_en    = 1'b1;
            tag_if.set      = flush_set_q;
            tag_if.wr_way   = '1;                         // Every way at once
            tag_if.wr_valid = 1'b0;
            if (flush_set_q == (icache_pkg::SET_WIDTH)'(icache_pkg::NB_SETS - 1))
            begin
               state_d = icache_pkg::ST_IDLE;
            end
         end
         icache_pkg::ST_IDLE:
         begin
            if (flush_icache_i)
            begin
               state_d = icache_pkg::ST_FLUSH;
            end
            else if (fetch_req_i)
            begin
               if (bypass_icache_i)
               begin
                  state_d = icache_pkg::ST_MISS_REQ;      // No lookup in bypass
               end
               else
               begin
                  tag_if.rd_en  = 1'b1;
                  data_if.rd_en = 1'b1;
                  tag_if.set    = fetch_addr_i[icache_pkg::SET_MSB:icache_pkg::SET_LSB];
                  data_if.set   = fetch_addr_i[icache_pkg::SET_MSB:icache_pkg::SET_LSB];
                  tag_if.tag    = fetch_addr_i[icache_pkg::FETCH_ADDR_WIDTH-1:icache_pkg::TAG_LSB];
                  state_d       = icache_pkg::ST_LOOKUP;
               end
            end
         end
         icache_pkg::ST_LOOKUP:
            state_d = lookup_hit ? icache_pkg::ST_IDLE : icache_pkg::ST_MISS_REQ;
         icache_pkg::ST_MISS_REQ:
         begin
            req_valid_o = 1'b1;
            if (req_ready_i)
            begin
               state_d = icache_pkg::ST_MISS_WAIT;
            end
         end
         icache_pkg::ST_MISS_WAIT:
         begin
            tag_if.wr_en = alloc;                         // Tag and line together
            if (resp_valid_i)
            begin
               state_d = icache_pkg::ST_IDLE;
            end
         end
         default: state_d = icache_pkg::ST_FLUSH;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Control registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q       <= icache_pkg::ST_FLUSH;           // Walk once after reset
         flush_set_q   <= '0;
         rr_q          <= '0;
         bypass_q      <= 1'b0;
         flushed_q     <= 1'b0;
         miss_rvalid_q <= 1'b0;
      end
      else
      begin
         state_q       <= state_d;
         miss_rvalid_q <= (state_q == icache_pkg::ST_MISS_WAIT) && resp_valid_i;
         if (state_q == icache_pkg::ST_FLUSH)
         begin
            flush_set_q <= flush_set_q + 1'b1;            // Wraps to 0 at the end
         end
         if (state_q == icache_pkg::ST_IDLE)
         begin
            bypass_q <= bypass_icache_i;
         end
         if ((state_q == icache_pkg::ST_FLUSH) && (state_d == icache_pkg::ST_IDLE))
         begin
            flushed_q <= 1'b1;
         end
         else if (alloc || (state_d == icache_pkg::ST_FLUSH))
         begin
            flushed_q <= 1'b0;
         end
         if (alloc)
         begin
            rr_q <= rr_q + 1'b1;                          // Round robin
         end
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (fetch_req_i && fetch_gnt_o)
      begin
         addr_q <= fetch_addr_i;
      end
      if (resp_valid_i)
      begin
         miss_rdata_q <= resp_data_i[word_sel*icache_pkg::FETCH_DATA_WIDTH +:
                                     icache_pkg::FETCH_DATA_WIDTH];
      end
   end

   // Grant stays low from acceptance until the answer, one fetch in flight
   a_single_fetch : assert property (@(posedge clk) disable iff (rst_i)
      (fetch_req_i && fetch_gnt_o) |=> (!fetch_gnt_o until fetch_rvalid_o));

endmodule

`default_nettype wire

// ==== src/pri_icache.sv ====
// Private instruction cache top level; connect the core fetch port and the refill memory port here
`default_nettype none

module pri_icache (
   input  wire                                         clk,
   input  wire                                         rst_i,
   // Core fetch port
   input  wire                                         fetch_req_i,
   input  wire  [icache_pkg::FETCH_ADDR_WIDTH-1:0]     fetch_addr_i,
   output logic                                        fetch_gnt_o,
   output logic                                        fetch_rvalid_o,
   output logic [icache_pkg::FETCH_DATA_WIDTH-1:0]     fetch_rdata_o,
   // Refill port to the next level
   output logic                                        refill_req_o,
   input  wire                                         refill_gnt_i,
   output logic [icache_pkg::FETCH_ADDR_WIDTH-1:0]     refill_addr_o,
   input  wire                                         refill_r_valid_i,
   input  wire  [icache_pkg::LINE_WIDTH-1:0]           refill_r_data_i,
   // Mode control
   input  wire                                         bypass_icache_i,
   output logic                                        cache_is_bypassed_o,
   input  wire                                         flush_icache_i,
   output logic                                        cache_is_flushed_o
);

   logic                                    req_valid;
   logic                                    req_ready;
   logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] req_addr;
   logic                                    resp_valid;
   logic [icache_pkg::LINE_WIDTH-1:0]       resp_data;

   icache_tag_if  tag_if ();
   icache_data_if data_if ();

   //////////////////////////////////////////////////////////////////////
   // Controller and memories
   //////////////////////////////////////////////////////////////////////
   icache_controller controller_inst (
      .clk                 (clk),
      .rst_i               (rst_i),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .bypass_icache_i     (bypass_icache_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .flush_icache_i      (flush_icache_i),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .tag_if              (tag_if.ctrl),
      .data_if             (data_if.ctrl),
      .req_valid_o         (req_valid),
      .req_addr_o          (req_addr),
      .req_ready_i         (req_ready),
      .resp_valid_i        (resp_valid),
      .resp_data_i         (resp_data)
   );

   icache_tag_bank  tag_bank_inst  (.clk(clk), .tag_if(tag_if.bank));
   icache_data_bank data_bank_inst (.clk(clk), .data_if(data_if.bank));

   //////////////////////////////////////////////////////////////////////
   // Refill buffers
   //////////////////////////////////////////////////////////////////////
   // Request side, held until refill_gnt_i
   icache_refill_buffer #(.DATA_WIDTH(icache_pkg::FETCH_ADDR_WIDTH)) req_buffer_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_valid_i (req_valid),
      .push_data_i  (req_addr),
      .push_ready_o (req_ready),
      .pop_valid_o  (refill_req_o),
      .pop_data_o   (refill_addr_o),
      .pop_ready_i  (refill_gnt_i)
   );

   // Response side; the controller drains it right away in miss-wait
   icache_refill_buffer #(.DATA_WIDTH(icache_pkg::LINE_WIDTH)) resp_buffer_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_valid_i (refill_r_valid_i),
      .push_data_i  (refill_r_data_i),
      .push_ready_o (),                    // Never full
      .pop_valid_o  (resp_valid),
      .pop_data_o   (resp_data),
      .pop_ready_i  (1'b1)
   );

endmodule

`default_nettype wire

// ==== dv/tb_pri_icache.sv ====
// Directed testbench for the instruction cache, with a refill memory model; run as the top module
`default_nettype none

module tb_pri_icache;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] WORD_KEY    = 32'h5a5a_c3c3;  // Memory word = byte address ^ key
   localparam int          NB_RANDOM   = 20;
   // Three flush walks plus about 40 fetches at a worst-case miss latency of 20, doubled
   localparam int          MAX_CYCLES  = 2000;

   logic         clk = 1'b0;
   logic         rst_i;
   logic         fetch_req_i;
   logic [31:0]  fetch_addr_i;
   logic         fetch_gnt_o;
   logic         fetch_rvalid_o;
   logic [31:0]  fetch_rdata_o;
   logic         refill_req_o;
   logic         refill_gnt_i;
   logic [31:0]  refill_addr_o;
   logic         refill_r_valid_i;
   logic [127:0] refill_r_data_i;
   logic         bypass_icache_i;
   logic         cache_is_bypassed_o;
   logic         flush_icache_i;
   logic         cache_is_flushed_o;

   integer       seed = 32'heeab_0ac3;
   int           errors = 0;
   int           fetches = 0;
   int           refill_count = 0;  // Granted refill requests
   int           cycle_count = 0;
   bit           bp_en = 1'b0;      // Random refill_gnt_i back-pressure
   bit           pending = 1'b0;    // One refill outstanding
   bit           req_held = 1'b0;
   int           resp_delay;
   logic [31:0]  pend_addr;
   logic [31:0]  held_addr;
   logic [31:0]  addr_list [NB_RANDOM];

   always #2 clk = ~clk;            // 4 ns period

   pri_icache pri_icache_inst (.*);

   // Line content of the memory model
   function automatic logic [127:0] line_data(input logic [31:0] line_addr);
      logic [127:0] line;
      for (int i = 0; i < 4; i++)
      begin
         line[i*32 +: 32] = (line_addr + 32'(4 * i)) ^ WORD_KEY;
      end
      return line;
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Refill memory model
   ////////////////////////////////////////////////////////////////////////
   always @(negedge clk)
   begin
      refill_r_valid_i = 1'b0;
      if (rst_i)
      begin
         refill_gnt_i = 1'b0;
         pending      = 1'b0;
         req_held     = 1'b0;
      end
      else
      begin
         if (pending)
         begin
            if (resp_delay == 0)
            begin
               refill_r_valid_i = 1'b1;
               refill_r_data_i  = line_data(pend_addr);
               pending          = 1'b0;
            end
            else
            begin
               resp_delay--;
            end
         end
         if (req_held)
         begin
            assert (refill_addr_o == held_addr)   // Held request must not change
            else
            begin
               $display("FAILED refill_addr_o changed: got %h, expected %h", refill_addr_o,
                        held_addr);
               errors++;
            end
         end
         refill_gnt_i = bp_en ? 1'($random(seed)) : 1'b1;
         if (refill_req_o && refill_gnt_i)          // Granted at the next rising edge
         begin
            assert (!pending) else
            begin
               $display("Second refill request granted while one is outstanding");
               errors++;
            end
            assert (refill_addr_o[3:0] == 4'h0) else
            begin
               $display("FAILED refill_addr_o not aligned: got %h", refill_addr_o);
               errors++;
            end
            pending    = 1'b1;
            pend_addr  = refill_addr_o;
            resp_delay = {$random(seed)} % 4;      // 1 to 4 cycles
            refill_count++;
         end
         req_held  = refill_req_o && !refill_gnt_i;
         held_addr = refill_addr_o;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Helper tasks
   ////////////////////////////////////////////////////////////////////////
   // One fetch; exp_refills < 0 skips the refill and latency checks
   task automatic fetch_check(input logic [31:0] addr, input int exp_refills);
      int          start_refills;
      int          lat;
      logic [31:0] exp_word;
      exp_word = {addr[31:2], 2'b00} ^ WORD_KEY;
      @(negedge clk);
      assert (!fetch_rvalid_o) else
      begin
         $display("Response seen with no fetch in flight, before fetch of %h", addr);
         errors++;
      end
      while (!fetch_gnt_o)
      begin
         @(negedge clk);
      end
      start_refills = refill_count;
      fetch_req_i   = 1'b1;
      fetch_addr_i  = addr;
      @(negedge clk);                              // Accepted at the edge before
      fetch_req_i   = 1'b0;
      fetch_addr_i  = '0;
      lat           = 1;
      while (!fetch_rvalid_o)
      begin
         assert (!fetch_gnt_o) else
         begin
            $display("FAILED fetch_gnt_o high while fetch %h is in flight", addr);
            errors++;
         end
         @(negedge clk);
         lat++;
      end
      fetches++;
      assert (fetch_rdata_o === exp_word) else
      begin
         $display("FAILED fetch_rdata_o at %h: got %h, expected %h", addr, fetch_rdata_o,
                  exp_word);
         errors++;
      end
      if (exp_refills >= 0)
      begin
         assert (refill_count - start_refills == exp_refills) else
         begin
            $display("FAILED refill_req_o count at %h: got %0h, expected %0h", addr,
                     refill_count - start_refills, exp_refills);
            errors++;
         end
      end
      if (exp_refills == 0)
      begin
         assert (lat == 1) else
         begin
            $display("FAILED fetch_rvalid_o latency at %h: got %0h, expected 1", addr, lat);
            errors++;
         end
      end
   endtask

   // Pulses flush_icache_i for one cycle while the controller is idle
   task automatic request_flush();
      @(negedge clk);
      while (!fetch_gnt_o)
      begin
         @(negedge clk);
      end
      flush_icache_i = 1'b1;
      @(negedge clk);
      flush_icache_i = 1'b0;
   endtask

   // Waits for the invalidate walk to end and grants to resume
   task automatic wait_walk();
      int cycles;
      cycles = 0;
      while (!(cache_is_flushed_o && fetch_gnt_o) && cycles < 2 * icache_pkg::NB_SETS)
      begin
         @(negedge clk);
         cycles++;
      end
      assert (cache_is_flushed_o && fetch_gnt_o) else
      begin
         $display("Flush walk did not finish within %0d cycles", cycles);
         errors++;
      end
      assert (cycles >= icache_pkg::NB_SETS) else
      begin
         $display("FAILED flush walk length: got %0h, expected %0h", cycles,
                  icache_pkg::NB_SETS);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////
   task automatic reset_then_first_fetch();
      assert (!fetch_gnt_o && !fetch_rvalid_o && !refill_req_o && !cache_is_flushed_o) else
      begin
         $display("FAILED outputs after reset: fetch_gnt_o %h fetch_rvalid_o %h",
                  fetch_gnt_o, fetch_rvalid_o);
         $display("FAILED outputs after reset: refill_req_o %h cache_is_flushed_o %h",
                  refill_req_o, cache_is_flushed_o);
         errors++;
      end
      wait_walk();
      fetch_check(32'h0000_1000, 1);
      assert (!cache_is_flushed_o) else
      begin
         $display("FAILED cache_is_flushed_o after allocation: got 1, expected 0");
         errors++;
      end
   endtask

   task automatic hits_in_same_line();
      fetch_check(32'h0000_1004, 0);
      fetch_check(32'h0000_1008, 0);
      fetch_check(32'h0000_100c, 0);
      fetch_check(32'h0000_1000, 0);
   endtask

   task automatic flush_then_refetch();
      request_flush();
      assert (!fetch_gnt_o) else
      begin
         $display("FAILED fetch_gnt_o during flush: got 1, expected 0");
         errors++;
      end
      wait_walk();
      fetch_check(32'h0000_1008, 1);               // Line was invalidated
   endtask

   // Set 4, tag stride 0x400
   task automatic set_eviction();
      for (int i = 0; i < 5; i++)
      begin
         fetch_check(32'h0000_2040 + 32'(i * 'h400), 1);
      end
      fetch_check(32'h0000_2044, 1);               // First line evicted, second goes now
      fetch_check(32'h0000_2848, 0);
      fetch_check(32'h0000_2c4c, 0);
      fetch_check(32'h0000_3040, 0);
   endtask

   task automatic bypass_fetches();
      @(negedge clk);
      while (!fetch_gnt_o)
      begin
         @(negedge clk);
      end
      bypass_icache_i = 1'b1;
      @(negedge clk);
      assert (cache_is_bypassed_o) else
      begin
         $display("FAILED cache_is_bypassed_o: got 0, expected 1");
         errors++;
      end
      fetch_check(32'h0000_5000, 1);
      fetch_check(32'h0000_5004, 1);               // Nothing was allocated
      fetch_check(32'h0000_1000, 1);               // Even a cached line
      while (!fetch_gnt_o)
      begin
         @(negedge clk);
      end
      bypass_icache_i = 1'b0;
      @(negedge clk);
      assert (!cache_is_bypassed_o) else
      begin
         $display("FAILED cache_is_bypassed_o: got 1, expected 0");
         errors++;
      end
      fetch_check(32'h0000_5008, 1);
      fetch_check(32'h0000_500c, 0);
   endtask

   // Starts from a freshly flushed cache so the first allocation must clear the flag
   task automatic random_with_backpressure();
      request_flush();
      wait_walk();
      @(posedge clk);
      bp_en = 1'b1;
      for (int i = 0; i < NB_RANDOM; i++)
      begin
         fetch_check(addr_list[i], -1);
      end
      bp_en = 1'b0;
      assert (!cache_is_flushed_o) else
      begin
         $display("FAILED cache_is_flushed_o: got 1, expected 0");
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Sequencing and watchdog
   ////////////////////////////////////////////////////////////////////////
   initial
   begin
      rst_i            = 1'b1;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      bypass_icache_i  = 1'b0;
      flush_icache_i   = 1'b0;
      for (int i = 0; i < NB_RANDOM; i++)
      begin
         addr_list[i] = {$random(seed)} & 32'h0000_1ffc;   // 8 KiB window gives hits and misses
      end
      repeat (4) @(negedge clk);
      rst_i = 1'b0;
      reset_then_first_fetch();
      hits_in_same_line();
      flush_then_refetch();
      set_eviction();
      bypass_fetches();
      random_with_backpressure();
      $display("Done: %0d fetches, %0d refills, %0d errors", fetches, refill_count, errors);
      if (errors == 0)
      begin
         $display("Result: PASSED");
      end
      else
      begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial
   begin
      while (cycle_count < MAX_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, a fetch or flush never completed", cycle_count);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
src/icache_pkg.sv
src/icache_if.sv
src/icache_tag_bank.sv
src/icache_data_bank.sv
src/icache_refill_buffer.sv
src/icache_controller.sv
src/pri_icache.sv
dv/tb_pri_icache.sv

// ==== Bender.yml ====
package:
  name: pri_icache

sources:
  - src/icache_pkg.sv
  - src/icache_if.sv
  - src/icache_tag_bank.sv
  - src/icache_data_bank.sv
  - src/icache_refill_buffer.sv
  - src/icache_controller.sv
  - src/pri_icache.sv
  - target: simulation
    files:
      - dv/tb_pri_icache.sv
